/* fe_frontend.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/fe_pkg.sv
hw/fe_pc_gen.sv
hw/fe_instr_scan.sv
hw/fe_bht.sv
hw/fe_fetch_queue.sv
hw/fe_frontend.sv
tests/fe_frontend_tb.sv

/* hw/fe_bht.sv */
// branch history table of 2-bit counters, read with the fetched pc and trained by back-end resolves
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_bht (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic [`FE_VLEN-1:0] pc_i,
    output fe_pkg::bht_pred_t   pred_o,
    input  fe_pkg::resolve_t    resolve_i
);

    import fe_pkg::*;

    localparam int unsigned IDX_W = $clog2(`FE_BHT_ENTRIES);

    logic [`FE_BHT_ENTRIES-1:0] valid_q;
    logic [1:0]                 cnt_q [`FE_BHT_ENTRIES];
    logic [IDX_W-1:0]           rd_idx;
    logic [IDX_W-1:0]           upd_idx;
    logic                       upd;

    // word offset bits are skipped
    assign rd_idx  = pc_i[IDX_W+1:2];
    assign upd_idx = resolve_i.pc[IDX_W+1:2];
    assign upd     = resolve_i.valid & (resolve_i.cf == Branch);

    // combinational read, counter msb is the direction
    always_comb begin
        pred_o.valid = valid_q[rd_idx];
        pred_o.taken = valid_q[rd_idx] & cnt_q[rd_idx][1];
    end

    // ---------------------------------------------
    // valid bits
    // ---------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // ---------------------------------------------
    // saturating counters
    // ---------------------------------------------
    always_ff @(posedge clk_i) begin
        if (upd) begin
            if (!valid_q[upd_idx]) begin
                // first sighting starts weak in the resolved direction
                cnt_q[upd_idx] <= resolve_i.is_taken ? 2'b10 : 2'b01;
            end else if (resolve_i.is_taken && cnt_q[upd_idx] != 2'b11) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
            end else if (!resolve_i.is_taken && cnt_q[upd_idx] != 2'b00) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
            end
        end
    end

endmodule

/* hw/fe_defs.svh */
// sizing macros for the fetch frontend, included by every RTL and testbench file that needs them
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// virtual address width
`define FE_VLEN 32

// branch history table entries, indexed by pc bits above the word offset
`define FE_BHT_ENTRIES 16

// fetch queue entries toward decode
`define FE_QUEUE_DEPTH 4

`endif

/* hw/fe_fetch_queue.sv */
// circular FIFO of scanned fetch entries toward decode, reporting room for all requests in flight
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_fetch_queue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  fe_pkg::fetch_entry_t entry_i,
    output logic                 room_o,
    output fe_pkg::fetch_entry_t entry_o,
    output logic                 valid_o,
    input  logic                 ready_i
);

    import fe_pkg::*;

    localparam int unsigned DEPTH    = `FE_QUEUE_DEPTH;
    localparam int unsigned PTR_W    = $clog2(DEPTH);
    localparam int unsigned CNT_W    = $clog2(DEPTH + 1);
    // push slot, response register and memory request all need a place
    localparam int unsigned ROOM_MAX = DEPTH - 3;

    fetch_entry_t     mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    assign valid_o = (count_q != '0);
    assign entry_o = mem_q[rd_ptr_q];
    assign pop     = valid_o & ready_i;
    assign room_o  = (count_q <= CNT_W'(ROOM_MAX));

    // ---------------------------------------------
    // pointers and fill level
    // ---------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage, overflow cannot happen while requests wait for room
    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

/* hw/fe_frontend.sv */
// RV32 fetch frontend top level, connects memory, back-end resolves and the decode queue
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_frontend (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic [`FE_VLEN-1:0]  boot_addr_i,
    input  fe_pkg::resolve_t     resolve_i,
    input  fe_pkg::redirect_t    redirect_i,
    output fe_pkg::fetch_req_t   fetch_req_o,
    input  fe_pkg::fetch_rsp_t   fetch_rsp_i,
    output fe_pkg::fetch_entry_t fetch_entry_o,
    output logic                 fetch_entry_valid_o,
    input  logic                 fetch_entry_ready_i
);

    import fe_pkg::*;
    import rv_isa_pkg::*;

    // response register
    logic                rsp_valid_q;
    logic [`FE_VLEN-1:0] rsp_vaddr_q;
    rv_instr_u           rsp_instr_q;

    cf_e                 cf;
    logic [`FE_VLEN-1:0] imm;
    bht_pred_t           bht_pred;
    logic                predict_taken;
    logic [`FE_VLEN-1:0] predict_addr;
    fetch_entry_t        entry;
    logic                push;

    logic                is_mispredict;
    logic                clear;        // drops everything fetched so far
    logic                kill;
    logic                queue_room;
    logic                fetch_room;
    logic                fetch_valid;
    logic [`FE_VLEN-1:0] fetch_addr;

    assign is_mispredict = resolve_i.valid & resolve_i.is_mispredict;
    assign clear         = is_mispredict | redirect_i.eret | redirect_i.ex_valid | flush_i;
    // a taken prediction only kills the word behind it, queued entries stay
    assign kill          = clear | predict_taken;
    assign fetch_room    = queue_room & ~flush_i;

    // ---------------------------------------------
    // memory response register
    // ---------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= fetch_rsp_i.valid & ~kill;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_rsp_i.valid) begin
            rsp_vaddr_q <= fetch_rsp_i.vaddr;
            rsp_instr_q <= fetch_rsp_i.data;
        end
    end

    // ---------------------------------------------
    // prediction
    // ---------------------------------------------
    always_comb begin
        predict_taken = 1'b0;
        if (rsp_valid_q) begin
            case (cf)
                Jump:    predict_taken = 1'b1;
                // no history yet, backward branches are taken
                Branch:  predict_taken = bht_pred.valid ? bht_pred.taken : imm[`FE_VLEN-1];
                default: predict_taken = 1'b0;
            endcase
        end
    end

    assign predict_addr = rsp_vaddr_q + imm;
    assign push         = rsp_valid_q & ~clear;

    always_comb begin
        entry.pc            = rsp_vaddr_q;
        entry.instr         = rsp_instr_q;
        entry.cf            = cf;
        entry.predict_taken = predict_taken;
        entry.predict_addr  = predict_addr;
    end

    always_comb begin
        fetch_req_o.valid = fetch_valid & ~kill;
        fetch_req_o.vaddr = fetch_addr;
        fetch_req_o.kill  = kill;
    end

    fe_pc_gen u_pc_gen (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .boot_addr_i     ( boot_addr_i   ),
        .room_i          ( fetch_room    ),
        .predict_taken_i ( predict_taken ),
        .predict_addr_i  ( predict_addr  ),
        .resolve_i       ( resolve_i     ),
        .redirect_i      ( redirect_i    ),
        .fetch_addr_o    ( fetch_addr    ),
        .fetch_valid_o   ( fetch_valid   )
    );

    fe_instr_scan u_instr_scan (
        .instr_i ( rsp_instr_q ),
        .cf_o    ( cf          ),
        .imm_o   ( imm         )
    );

    fe_bht u_bht (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .flush_i   ( flush_i     ),
        .pc_i      ( rsp_vaddr_q ),
        .pred_o    ( bht_pred    ),
        .resolve_i ( resolve_i   )
    );

    fe_fetch_queue u_fetch_queue (
        .clk_i   ( clk_i               ),
        .rst_ni  ( rst_ni              ),
        .flush_i ( clear               ),
        .push_i  ( push                ),
        .entry_i ( entry               ),
        .room_o  ( queue_room          ),
        .entry_o ( fetch_entry_o       ),
        .valid_o ( fetch_entry_valid_o ),
        .ready_i ( fetch_entry_ready_i )
    );

endmodule

/* hw/fe_instr_scan.sv */
// control-flow scan of one fetched word, used combinationally on the response register
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_instr_scan (
    input  rv_isa_pkg::rv_instr_u instr_i,
    output fe_pkg::cf_e           cf_o,
    output logic [`FE_VLEN-1:0]   imm_o
);

    import rv_isa_pkg::*;
    import fe_pkg::*;

    logic [`FE_VLEN-1:0] b_imm;
    logic [`FE_VLEN-1:0] j_imm;

    // branch offset, sign from bit 31, bit 0 always zero
    assign b_imm = {{(`FE_VLEN-12){instr_i.btype.imm12}},
                    instr_i.btype.imm11,
                    instr_i.btype.imm10_5,
                    instr_i.btype.imm4_1,
                    1'b0};

    // jal offset, 21 bits before extension
    assign j_imm = {{(`FE_VLEN-20){instr_i.jtype.imm20}},
                    instr_i.jtype.imm19_12,
                    instr_i.jtype.imm11,
                    instr_i.jtype.imm10_1,
                    1'b0};

    // opcode sits at the same place in both views
    always_comb begin
        cf_o  = NoCF;
        imm_o = '0;
        case (instr_i.btype.opcode)
            BRANCH: begin
                cf_o  = Branch;
                imm_o = b_imm;
            end
            JAL: begin
                cf_o  = Jump;
                imm_o = j_imm;
            end
            // target comes from a register, flagged only
            JALR: begin
                cf_o = JumpR;
            end
            default: begin
                cf_o = NoCF;
            end
        endcase
    end

endmodule

/* hw/fe_pc_gen.sv */
// next-PC register and fetch address selection, instantiated once by the frontend top level
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_pc_gen (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [`FE_VLEN-1:0] boot_addr_i,
    input  logic                room_i,
    input  logic                predict_taken_i,
    input  logic [`FE_VLEN-1:0] predict_addr_i,
    input  fe_pkg::resolve_t    resolve_i,
    input  fe_pkg::redirect_t   redirect_i,
    output logic [`FE_VLEN-1:0] fetch_addr_o,
    output logic                fetch_valid_o
);

    localparam logic [`FE_VLEN-1:0] PC_STEP = 4;

    logic [`FE_VLEN-1:0] npc_d, npc_q;
    logic                rst_load_q;   // first active cycle fetches from boot_addr_i
    logic                run_q;        // no requests until one edge after reset
    logic                is_mispredict;
    logic                issued;

    assign is_mispredict = resolve_i.valid & resolve_i.is_mispredict;

    // a taken prediction kills this cycle's request, so it never counts as issued
    assign fetch_valid_o = room_i & run_q;
    assign issued        = fetch_valid_o & ~predict_taken_i;

    // ---------------------------------------------
    // next pc select, later lines win
    // ---------------------------------------------
    always_comb begin
        fetch_addr_o = rst_load_q ? boot_addr_i : npc_q;
        // hold by default
        npc_d = fetch_addr_o;
        if (predict_taken_i) begin
            npc_d = predict_addr_i;
        end
        // sequential word after a request went out
        if (issued) begin
            npc_d = {fetch_addr_o[`FE_VLEN-1:2], 2'b00} + PC_STEP;
        end
        if (is_mispredict) begin
            npc_d = resolve_i.target;
        end
        if (redirect_i.eret) begin
            npc_d = redirect_i.epc;
        end
        // exceptions override everything
        if (redirect_i.ex_valid) begin
            npc_d = redirect_i.trap_base;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q      <= '0;
            rst_load_q <= 1'b1;
            run_q      <= 1'b0;
        end else begin
            npc_q      <= npc_d;
            run_q      <= 1'b1;
            // boot address only stays selected until the first running cycle
            rst_load_q <= rst_load_q & ~run_q;
        end
    end

endmodule

/* hw/fe_pkg.sv */
// transaction types exchanged by the fetch frontend with memory, back-end and decode
`include "fe_defs.svh"

package fe_pkg;

    // control-flow kind of a fetched instruction
    typedef enum logic [1:0] {
        NoCF,
        Branch,
        Jump,
        JumpR
    } cf_e;

    // ---------------------------------------------
    // memory side
    // ---------------------------------------------
    typedef struct packed {
        logic                valid;
        logic [`FE_VLEN-1:0] vaddr;
        logic                kill;   // cancels the request of the previous cycle
    } fetch_req_t;

    typedef struct packed {
        logic                valid;
        logic [`FE_VLEN-1:0] vaddr;
        logic [31:0]         data;
    } fetch_rsp_t;

    // ---------------------------------------------
    // back-end side
    // ---------------------------------------------
    typedef struct packed {
        logic                valid;
        logic [`FE_VLEN-1:0] pc;
        logic [`FE_VLEN-1:0] target;
        logic                is_taken;
        logic                is_mispredict;
        cf_e                 cf;
    } resolve_t;

    typedef struct packed {
        logic                eret;
        logic [`FE_VLEN-1:0] epc;
        logic                ex_valid;
        logic [`FE_VLEN-1:0] trap_base;
    } redirect_t;

    // one queued instruction toward decode
    typedef struct packed {
        logic [`FE_VLEN-1:0] pc;
        logic [31:0]         instr;
        cf_e                 cf;
        logic                predict_taken;
        logic [`FE_VLEN-1:0] predict_addr;
    } fetch_entry_t;

    // table lookup result
    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

endpackage

/* hw/rv_isa_pkg.sv */
// RV32 instruction encoding types, imported by the frontend blocks that decode fetched words
package rv_isa_pkg;

    // base opcodes, only the control-flow ones are decoded in fetch
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } rv_opcode_e;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        rv_opcode_e opcode;
    } rv_btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        rv_opcode_e opcode;
    } rv_jtype_t;

    // same 32-bit word, two immediate layouts
    typedef union packed {
        rv_btype_t btype;
        rv_jtype_t jtype;
    } rv_instr_u;

endpackage

/* tests/fe_frontend_tb.sv */
// self-checking fetch frontend testbench run from the project root on its data file
`include "fe_defs.svh"
`timescale 1ns/10ps

module fe_frontend_tb;

    import fe_pkg::*;

    localparam int unsigned MEM_WORDS  = 1024;
    localparam int unsigned FILE_WORDS = 512;
    localparam int unsigned REC_W      = 6;

    logic                clk_i;
    logic                rst_ni;
    logic                flush;
    logic [`FE_VLEN-1:0] boot_addr;
    resolve_t            resolve;
    redirect_t           redirect;
    fetch_req_t          req;
    fetch_rsp_t          rsp;
    fetch_entry_t        entry;
    logic                entry_valid;
    logic                entry_ready;

    // instruction memory and the one response in flight
    logic [31:0]         mem [MEM_WORDS];
    logic                pend_valid;
    logic [`FE_VLEN-1:0] pend_addr;
    logic                req_valid_s;
    logic [`FE_VLEN-1:0] req_addr_s;

    // records from the data file
    logic [31:0]         file_words [FILE_WORDS];
    fetch_entry_t        exp_q [$];
    logic [31:0]         ev_count [$];
    logic [31:0]         ev_mask [$];
    logic [31:0]         ev_pc [$];
    logic [31:0]         ev_target [$];

    integer              seed = 32'hbeff_3f45;
    int                  n_errors;
    int                  n_checked;
    int                  n_consumed;
    int                  n_cycles;
    int                  ev_ptr;

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // a kill in the response cycle drops the answer to the previous request
    always_comb begin
        rsp.valid = pend_valid & ~req.kill;
        rsp.vaddr = pend_addr;
        rsp.data  = mem[pend_addr[11:2]];
    end

    fe_frontend uut (
        .clk_i               ( clk_i       ),
        .rst_ni              ( rst_ni      ),
        .flush_i             ( flush       ),
        .boot_addr_i         ( boot_addr   ),
        .resolve_i           ( resolve     ),
        .redirect_i          ( redirect    ),
        .fetch_req_o         ( req         ),
        .fetch_rsp_i         ( rsp         ),
        .fetch_entry_o       ( entry       ),
        .fetch_entry_valid_o ( entry_valid ),
        .fetch_entry_ready_i ( entry_ready )
    );

    // ------------------------------------------------
    // data file
    // ------------------------------------------------
    task automatic load_tests();
        int           rec;
        int           b;
        fetch_entry_t e;
        // unlisted words are addi x0, x0, <byte address>
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {a[9:0], 2'b00, 20'h00013};
        end
        for (int w = 0; w < FILE_WORDS; w++) begin
            file_words[w] = '0;
        end
        $readmemh("tests/fe_frontend_tests.txt", file_words);
        rec = 0;
        while (rec < FILE_WORDS / REC_W && file_words[rec * REC_W] != 0) begin
            b = rec * REC_W;
            case (file_words[b])
                1: boot_addr = file_words[b + 1];
                2: mem[file_words[b + 1][11:2]] = file_words[b + 2];
                3: begin
                    ev_count.push_back(file_words[b + 1]);
                    ev_mask.push_back(file_words[b + 2]);
                    ev_pc.push_back(file_words[b + 3]);
                    ev_target.push_back(file_words[b + 4]);
                end
                4: begin
                    e.pc            = file_words[b + 1];
                    e.instr         = file_words[b + 2];
                    e.cf            = cf_e'(file_words[b + 3][1:0]);
                    e.predict_taken = file_words[b + 4][0];
                    e.predict_addr  = file_words[b + 5];
                    exp_q.push_back(e);
                end
                default: begin
                    n_errors++;
                    $display("data file record %0d has an unknown tag %h", rec, file_words[b]);
                end
            endcase
            rec++;
        end
        if (exp_q.size() == 0) begin
            n_errors++;
            $display("data file holds no expected entries");
        end
    endtask

    // ------------------------------------------------
    // checks
    // ------------------------------------------------
    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            n_errors++;
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_entry(fetch_entry_t got, fetch_entry_t exp, int idx);
        check_value($sformatf("fetch_entry_o.pc (entry %0d)", idx), got.pc, exp.pc);
        check_value($sformatf("fetch_entry_o.instr (entry %0d)", idx), got.instr, exp.instr);
        check_value($sformatf("fetch_entry_o.cf (entry %0d)", idx), got.cf, exp.cf);
        check_value($sformatf("fetch_entry_o.predict_taken (entry %0d)", idx),
                    got.predict_taken, exp.predict_taken);
        // the target only means something for a taken prediction
        if (exp.predict_taken) begin
            check_value($sformatf("fetch_entry_o.predict_addr (entry %0d)", idx),
                        got.predict_addr, exp.predict_addr);
        end
        n_checked++;
    endtask

    // event mask bits from lsb are resolve, mispredict, trap, eret and flush
    task automatic drive_event(logic [31:0] mask, logic [31:0] pc, logic [31:0] target);
        resolve.valid         = mask[0];
        resolve.pc            = pc;
        resolve.target        = target;
        resolve.is_taken      = 1'b1;
        resolve.is_mispredict = mask[1];
        resolve.cf            = Branch;
        redirect.ex_valid     = mask[2];
        redirect.trap_base    = target;
        redirect.eret         = mask[3];
        redirect.epc          = target;
        flush                 = mask[4];
    endtask

    task automatic end_run();
        $display("errors: %0d, entries checked: %0d of %0d", n_errors, n_checked, exp_q.size());
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // ------------------------------------------------
    // main sequence
    // ------------------------------------------------
    initial begin
        int   r;
        int   limit;
        logic fire;
        logic expect_kill;
        n_errors    = 0;
        n_checked   = 0;
        n_consumed  = 0;
        n_cycles    = 0;
        ev_ptr      = 0;
        rst_ni      = 1'b0;
        flush       = 1'b0;
        boot_addr   = '0;
        resolve     = '0;
        redirect    = '0;
        entry_ready = 1'b0;
        pend_valid  = 1'b0;
        pend_addr   = '0;
        req_valid_s = 1'b0;
        req_addr_s  = '0;
        load_tests();

        repeat (8) @(posedge clk_i);
        #5;
        // outputs are frozen while reset is held
        check_value("fetch_req_o.valid in reset", req.valid, 1'b0);
        check_value("fetch_req_o.kill in reset", req.kill, 1'b0);
        check_value("fetch_entry_valid_o in reset", entry_valid, 1'b0);
        rst_ni = 1'b1;

        limit = 20 * exp_q.size() + 100;
        while (n_consumed < exp_q.size() && n_cycles < limit) begin
            @(posedge clk_i);
            #5;
            // answer the request accepted last cycle
            pend_valid = req_valid_s;
            pend_addr  = req_addr_s;
            drive_event('0, '0, '0);
            fire = (ev_ptr < ev_count.size()) && (n_consumed >= ev_count[ev_ptr]);
            expect_kill = 1'b0;
            if (fire) begin
                drive_event(ev_mask[ev_ptr], ev_pc[ev_ptr], ev_target[ev_ptr]);
                // mispredict, trap, eret and flush all drop the fetch stream
                expect_kill = (ev_mask[ev_ptr][4:1] != 4'b0000);
                ev_ptr++;
            end
            // decode stalls on event cycles and otherwise accepts three times in four
            r = $random(seed);
            entry_ready = fire ? 1'b0 : (r[1:0] != 2'b00);

            @(negedge clk_i);
            req_valid_s = req.valid;
            req_addr_s  = req.vaddr;
            // a redirect kills the word in flight and cancels this cycle's request
            if (expect_kill) begin
                check_value("fetch_req_o.kill on redirect", req.kill, 1'b1);
                check_value("fetch_req_o.valid on redirect", req.valid, 1'b0);
            end
            if (entry_valid && entry_ready) begin
                check_entry(entry, exp_q[n_consumed], n_consumed);
                n_consumed++;
            end
            n_cycles++;
        end

        if (n_consumed < exp_q.size()) begin
            n_errors++;
            $display("timeout after %0d cycles: entry %0d of %0d with pc %h never arrived",
                     n_cycles, n_consumed, exp_q.size(), exp_q[n_consumed].pc);
        end
        end_run();
    end

endmodule

/* tests/fe_frontend_tests.txt */
// records of six hex words: tag f1 f2 f3 f4 f5; tag 1 boot addr, 2 memory addr data,
// 3 event count mask pc target (mask 01 resolve 02 mispredict 04 trap 08 eret 10 flush),
// 4 expected pc instr cf taken target (cf 0 none 1 branch 2 jal 3 jalr); counts are hex
1 00000100 0 0 0 0
// program words, everything else is addi x0, x0, addr
2 0000010c 0200006f 0 0 0
2 00000130 00209863 0 0 0
2 00000134 fe418ae3 0 0 0
2 00000144 fe9ff06f 0 0 0
2 00000204 00008067 0 0 0
2 00000208 f25ff06f 0 0 0
// train the forward branch, then mispredict it, trap, and flush with eret
3 0000000a 01 00000130 00000140 0
3 0000000a 03 00000130 00000140 0
3 00000010 04 00000000 00000200 0
3 00000016 18 00000000 00000120 0
// boot, jal, static forward and backward branches
4 00000100 10000013 0 0 00000000
4 00000104 10400013 0 0 00000000
4 00000108 10800013 0 0 00000000
4 0000010c 0200006f 2 1 0000012c
4 0000012c 12c00013 0 0 00000000
4 00000130 00209863 1 0 00000000
4 00000134 fe418ae3 1 1 00000128
4 00000128 12800013 0 0 00000000
4 0000012c 12c00013 0 0 00000000
4 00000130 00209863 1 0 00000000
// after the mispredict, the trained branch goes taken
4 00000140 14000013 0 0 00000000
4 00000144 fe9ff06f 2 1 0000012c
4 0000012c 12c00013 0 0 00000000
4 00000130 00209863 1 1 00000140
4 00000140 14000013 0 0 00000000
4 00000144 fe9ff06f 2 1 0000012c
// trap handler with jalr
4 00000200 20000013 0 0 00000000
4 00000204 00008067 3 0 00000000
4 00000208 f25ff06f 2 1 0000012c
4 0000012c 12c00013 0 0 00000000
4 00000130 00209863 1 1 00000140
4 00000140 14000013 0 0 00000000
// eret after flush, table empty again
4 00000120 12000013 0 0 00000000
4 00000124 12400013 0 0 00000000
4 00000128 12800013 0 0 00000000
4 0000012c 12c00013 0 0 00000000
4 00000130 00209863 1 0 00000000
4 00000134 fe418ae3 1 1 00000128
4 00000128 12800013 0 0 00000000
0 0 0 0 0 0
